// File: source/div_defines.svh
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

////////////////////
// Divide unit sizing

// Operand and result width, one machine word
`define DIV_XLEN 32

// Instruction id carried from issue to writeback
`define DIV_ID_W 3

// Entries in the request FIFO ahead of the divider
// Issue stalls once this many requests are waiting
`define DIV_FIFO_DEPTH 4

`endif

// File: source/div_pkg.sv
`include "div_defines.svh"

package div_pkg;

    ////////////////////
    // Scalar types

    // One machine word
    typedef logic [`DIV_XLEN-1:0] div_word_t;

    // Instruction id
    typedef logic [`DIV_ID_W-1:0] div_id_t;

    // Low two bits of the RISC-V funct3
    // Bit 0 set selects unsigned, bit 1 set selects remainder
    typedef enum logic [1:0] {
        DIV_OP_DIV  = 2'b00,
        DIV_OP_DIVU = 2'b01,
        DIV_OP_REM  = 2'b10,
        DIV_OP_REMU = 2'b11
    } div_op_t;

    ////////////////////
    // Payloads

    // Request as held in the input FIFO
    typedef struct packed {
        div_op_t   op;
        div_word_t rs1;
        div_word_t rs2;
        div_id_t   id;
    } div_request_t;

    // Writeback payload, qualified by done
    typedef struct packed {
        div_word_t rd;
        div_id_t   id;
    } div_result_t;

endpackage

// File: source/fifo_if.sv
interface fifo_if #(
    parameter type T = logic
);

    // Write side
    logic push;
    T     data_in;

    // Read side
    logic pop;
    T     data_out;

    // Status from the storage
    logic valid;
    logic full;

    // Writer, sees full for its own stall
    modport producer (output push, output data_in, input full);

    // Reader, oldest entry shown on data_out while valid
    modport consumer (output pop, input data_out, input valid);

    // The buffer itself
    modport storage (
        input  push,
        input  pop,
        input  data_in,
        output data_out,
        output valid,
        output full
    );

endinterface

// File: source/div_fifo.sv
module div_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input logic    clk,
    input logic    rst,
    fifo_if.storage fifo
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage
    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    ////////////////////
    // Qualified strobes

    // Push dropped when full, pop only with an entry present
    assign do_push = fifo.push & ~fifo.full;
    assign do_pop  = fifo.pop & fifo.valid;

    ////////////////////
    // Pointers and count

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // Wrap explicitly so DEPTH need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Net occupancy change
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Write port
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= fifo.data_in;
        end
    end

    ////////////////////
    // Read side

    // Head is the oldest entry, one cycle after its push
    assign fifo.data_out = mem[rd_ptr];
    assign fifo.valid    = (count != '0);
    assign fifo.full     = (count == CNT_W'(DEPTH));

endmodule

// File: source/radix2_divider.sv
`include "div_defines.svh"

module radix2_divider import div_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [`DIV_XLEN-1:0] dividend,
    input  logic [`DIV_XLEN-1:0] divisor,
    output logic [`DIV_XLEN-1:0] quotient,
    output logic [`DIV_XLEN-1:0] remainder,
    output logic                 divisor_zero,
    output logic                 complete
);

    localparam int CNT_W = $clog2(`DIV_XLEN);

    // Iteration state
    logic             running;
    logic [CNT_W-1:0] count;

    // Quotient register, starts as the dividend and shifts left
    // Dividend bits leave the top as quotient bits enter the bottom
    div_word_t quo_r;
    div_word_t rem_r;
    div_word_t divisor_r;
    logic      dz_r;

    // One restoring step
    logic [`DIV_XLEN:0]   partial;
    logic [`DIV_XLEN+1:0] diff;
    logic                 fits;

    ////////////////////
    // Shift and subtract

    // Next dividend bit into the partial remainder
    assign partial = {rem_r, quo_r[`DIV_XLEN-1]};

    // Extra top bit keeps the borrow as a sign
    assign diff = {1'b0, partial} - {2'b00, divisor_r};
    assign fits = ~diff[`DIV_XLEN+1];

    ////////////////////
    // Control

    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            count    <= '0;
            complete <= 1'b0;
        end else begin
            complete <= 1'b0;
            if (start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                // Last bit done, results valid in the next cycle
                if (count == CNT_W'(`DIV_XLEN - 1)) begin
                    running  <= 1'b0;
                    complete <= 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Datapath

    always_ff @(posedge clk) begin
        if (start) begin
            // Load operands, partial remainder starts empty
            quo_r     <= dividend;
            rem_r     <= '0;
            divisor_r <= divisor;
            dz_r      <= (divisor == '0);
        end else if (running) begin
            // Keep the difference only when it did not borrow
            if (fits) begin
                rem_r <= diff[`DIV_XLEN-1:0];
            end else begin
                rem_r <= partial[`DIV_XLEN-1:0];
            end
            quo_r <= {quo_r[`DIV_XLEN-2:0], fits};
        end
    end

    // Zero divisor never borrows
    // Quotient ends all ones, remainder ends equal to the dividend
    assign quotient     = quo_r;
    assign remainder    = rem_r;
    assign divisor_zero = dz_r;

endmodule

// File: source/div_unit.sv
`include "div_defines.svh"

module div_unit import div_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         new_request,
    input  div_request_t request,
    output logic         ready,
    fifo_if.producer     in_fifo,
    fifo_if.consumer     out_fifo,
    output div_result_t  wb,
    output logic         done
);

    localparam int MSB = `DIV_XLEN - 1;

    // FIFO head
    div_request_t head;

    // Sequencing
    logic busy;
    logic start;
    logic complete;
    logic reuse;
    logic match;

    // Sign handling
    logic signed_op;
    logic dividend_neg;
    logic divisor_neg;
    logic quotient_neg;
    logic remainder_neg;
    logic negate;

    // Magnitudes in, raw results out
    div_word_t mag_a;
    div_word_t mag_b;
    div_word_t quotient;
    div_word_t remainder;
    logic      divisor_zero;
    div_word_t raw_result;

    // Operands of the last completed divide
    logic      last_valid;
    div_word_t last_rs1;
    div_word_t last_rs2;
    logic      last_signed;

    ////////////////////
    // Issue side

    assign in_fifo.push    = new_request;
    assign in_fifo.data_in = request;
    assign ready           = ~in_fifo.full;

    assign head = out_fifo.data_out;

    ////////////////////
    // Sequencing

    // Same operands and signedness as the last divide
    // DIV then REM on one pair lands here
    assign match = last_valid & (head.rs1 == last_rs1) & (head.rs2 == last_rs2) &
                   (signed_op == last_signed);

    assign reuse = out_fifo.valid & ~busy & match;
    assign start = out_fifo.valid & ~busy & ~match;

    // Head leaves the FIFO on its done
    assign done         = complete | reuse;
    assign out_fifo.pop = done;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (complete) begin
            busy <= 1'b0;
        end
    end

    // Record taken while the finished request is still the head
    always_ff @(posedge clk) begin
        if (rst) begin
            last_valid <= 1'b0;
        end else if (complete) begin
            last_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (complete) begin
            last_rs1    <= head.rs1;
            last_rs2    <= head.rs2;
            last_signed <= signed_op;
        end
    end

    ////////////////////
    // Signs

    assign signed_op     = ~head.op[0];
    assign dividend_neg  = signed_op & head.rs1[MSB];
    assign divisor_neg   = signed_op & head.rs2[MSB];
    assign quotient_neg  = dividend_neg ^ divisor_neg;
    assign remainder_neg = dividend_neg;

    // Two's complement magnitudes
    // Most negative value maps onto itself, read as unsigned
    assign mag_a = ({`DIV_XLEN{dividend_neg}} ^ head.rs1) + div_word_t'(dividend_neg);
    assign mag_b = ({`DIV_XLEN{divisor_neg}} ^ head.rs2) + div_word_t'(divisor_neg);

    ////////////////////
    // Divider core

    radix2_divider divider_inst (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .dividend     (mag_a),
        .divisor      (mag_b),
        .quotient     (quotient),
        .remainder    (remainder),
        .divisor_zero (divisor_zero),
        .complete     (complete)
    );

    ////////////////////
    // Result

    // All-ones quotient on divide by zero stays as is
    assign negate     = head.op[1] ? remainder_neg : (quotient_neg & ~divisor_zero);
    assign raw_result = head.op[1] ? remainder : quotient;

    assign wb.rd = ({`DIV_XLEN{negate}} ^ raw_result) + div_word_t'(negate);
    assign wb.id = head.id;

endmodule

// File: source/div_subsystem.sv
`include "div_defines.svh"

module div_subsystem import div_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // Issue
    input  logic                 new_request,
    input  div_op_t              op,
    input  logic [`DIV_XLEN-1:0] rs1,
    input  logic [`DIV_XLEN-1:0] rs2,
    input  logic [`DIV_ID_W-1:0] req_id,
    output logic                 ready,

    // Writeback, no back-pressure
    output logic                 done,
    output logic [`DIV_XLEN-1:0] rd,
    output logic [`DIV_ID_W-1:0] wb_id
);

    div_request_t request;
    div_result_t  wb;

    // Request FIFO between issue and the divider
    fifo_if #(.T(div_request_t)) req_fifo ();

    ////////////////////
    // Port packing

    assign request.op  = op;
    assign request.rs1 = rs1;
    assign request.rs2 = rs2;
    assign request.id  = req_id;

    assign rd    = wb.rd;
    assign wb_id = wb.id;

    ////////////////////
    // Instances

    div_fifo #(
        .T     (div_request_t),
        .DEPTH (`DIV_FIFO_DEPTH)
    ) req_fifo_inst (
        .clk  (clk),
        .rst  (rst),
        .fifo (req_fifo)
    );

    // Unit writes and reads the same FIFO through two views
    div_unit div_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .new_request (new_request),
        .request     (request),
        .ready       (ready),
        .in_fifo     (req_fifo),
        .out_fifo    (req_fifo),
        .wb          (wb),
        .done        (done)
    );

endmodule

// File: dv/div_assert.sv
`include "div_defines.svh"

module div_assert (
    input logic clk,
    input logic rst,
    input logic new_request,
    input logic ready,
    input logic start,
    input logic complete,
    input logic done,
    input logic head_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertions so far
    int fail_count = 0;

    ////////////////////
    // Issue side

    issue_when_ready: assert property (@(posedge clk) disable iff (rst)
        new_request |-> ready)
    else begin
        $error("request issued while the FIFO was full");
        fail_count++;
    end

    ////////////////////
    // Divider progress

    // One quotient bit per cycle after the load
    start_to_complete: assert property (@(posedge clk) disable iff (rst)
        start |-> ##(`DIV_XLEN + 1) complete)
    else begin
        $error("divider complete did not follow start on time");
        fail_count++;
    end

    // Writeback only for a request at the head
    done_has_head: assert property (@(posedge clk) disable iff (rst)
        done |-> head_valid)
    else begin
        $error("done pulsed with an empty FIFO");
        fail_count++;
    end

    // Quiet writeback out of reset
    done_low_after_reset: assert property (@(posedge clk)
        rst |=> !done)
    else begin
        $error("done high right after reset");
        fail_count++;
    end

endmodule

bind div_unit div_assert div_assert_inst (
    .clk         (clk),
    .rst         (rst),
    .new_request (new_request),
    .ready       (ready),
    .start       (start),
    .complete    (complete),
    .done        (done),
    .head_valid  (out_fifo.valid)
);

// File: dv/div_tb.sv
`include "div_defines.svh"

module div_tb import div_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // 80 requests over all tests, each at most one full divide plus a cycle
    localparam int NUM_REQUESTS = 80;
    localparam int CYCLE_LIMIT  = NUM_REQUESTS * (`DIV_XLEN + 2) + 10 + 400;

    localparam div_word_t MOST_NEG = {1'b1, {(`DIV_XLEN-1){1'b0}}};
    localparam div_word_t ALL_ONES = '1;

    // DUT ports
    logic      clk;
    logic      rst;
    logic      new_request;
    div_op_t   op;
    div_word_t rs1;
    div_word_t rs2;
    div_id_t   req_id;
    logic      ready;
    logic      done;
    div_word_t rd;
    div_id_t   wb_id;

    // Scoreboard, one entry per accepted request still in flight
    div_result_t expected_q[$];
    int          done_cycles[$];
    logic        can_issue;
    logic        ready_low_seen;

    int        cycle;
    int        issued;
    int        results_checked;
    int        value_errors;
    int        protocol_errors;
    int        assert_failures;
    div_id_t   next_id;
    div_word_t lfsr;

    div_subsystem div_subsystem_inst (
        .clk         (clk),
        .rst         (rst),
        .new_request (new_request),
        .op          (op),
        .rs1         (rs1),
        .rs2         (rs2),
        .req_id      (req_id),
        .ready       (ready),
        .done        (done),
        .rd          (rd),
        .wb_id       (wb_id)
    );

    always #10 clk = ~clk;

    ////////////////////
    // Reference model

    // RISC-V M rules, quotient truncates toward zero
    function automatic div_word_t model_rd(input div_op_t o, input div_word_t a,
                                           input div_word_t b);
        logic signed [`DIV_XLEN-1:0] sa;
        logic signed [`DIV_XLEN-1:0] sb;
        div_word_t                   r;
        sa = a;
        sb = b;
        case (o)
            DIV_OP_DIVU: r = (b == '0) ? ALL_ONES : a / b;
            DIV_OP_REMU: r = (b == '0) ? a : a % b;
            DIV_OP_DIV: begin
                if (b == '0)
                    r = ALL_ONES;
                else if (a == MOST_NEG && b == ALL_ONES)
                    r = MOST_NEG;
                else
                    r = sa / sb;
            end
            default: begin
                // Remainder keeps the dividend's sign
                if (b == '0)
                    r = a;
                else if (a == MOST_NEG && b == ALL_ONES)
                    r = '0;
                else
                    r = sa % sb;
            end
        endcase
        return r;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic div_word_t lfsr_step(input div_word_t s);
        return {s[`DIV_XLEN-2:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output div_word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[`DIV_XLEN-2:0], lfsr[0]};
        end
    endtask

    ////////////////////
    // Compare tasks

    task automatic check_result(input div_result_t got, input div_result_t exp);
        results_checked++;
        if (got !== exp) begin
            $display("FAIL %0t: rd=%h id=%0d, expected rd=%h id=%0d",
                     $time, got.rd, got.id, exp.rd, exp.id);
            value_errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            value_errors++;
        end
    endtask

    ////////////////////
    // Monitor

    // Outputs settle by the falling edge
    always @(negedge clk) begin
        div_result_t got;
        logic        accept;
        if (!rst) begin
            accept = new_request && ready;
            // Ready is high until DIV_FIFO_DEPTH requests wait
            check_flag(ready, logic'(expected_q.size() < `DIV_FIFO_DEPTH), "ready");
            if (!ready)
                ready_low_seen = 1'b1;
            if (done) begin
                got.rd = rd;
                got.id = wb_id;
                done_cycles.push_back(cycle);
                if (expected_q.size() == 0) begin
                    $display("Error: done pulsed at %0t with no request outstanding", $time);
                    protocol_errors++;
                end else begin
                    check_result(got, expected_q.pop_front());
                end
            end
            if (accept) begin
                got.rd = model_rd(op, rs1, rs2);
                got.id = req_id;
                expected_q.push_back(got);
            end
            // Room for one more after the coming edge
            can_issue = (expected_q.size() < `DIV_FIFO_DEPTH);
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    ////////////////////
    // Drivers

    // Held back while the FIFO would be full
    task automatic issue(input div_op_t o, input div_word_t a, input div_word_t b);
        @(posedge clk);
        while (!can_issue) begin
            new_request <= 1'b0;
            @(posedge clk);
        end
        new_request <= 1'b1;
        op          <= o;
        rs1         <= a;
        rs2         <= b;
        req_id      <= next_id;
        next_id = next_id + 1'b1;
        issued++;
    endtask

    task automatic issue_all_ops(input div_word_t a, input div_word_t b);
        issue(DIV_OP_DIV, a, b);
        issue(DIV_OP_DIVU, a, b);
        issue(DIV_OP_REM, a, b);
        issue(DIV_OP_REMU, a, b);
    endtask

    // Stop issuing, wait for every result
    task automatic drain();
        @(posedge clk);
        new_request <= 1'b0;
        while (expected_q.size() != 0)
            @(posedge clk);
    endtask

    ////////////////////
    // Tests

    task automatic test_mixed_signs();
        issue_all_ops(32'd20, 32'd6);
        issue_all_ops(32'hFFFF_FFEC, 32'd6);
        issue_all_ops(32'd20, 32'hFFFF_FFFA);
        issue_all_ops(32'hFFFF_FFEC, 32'hFFFF_FFFA);
        drain();
    endtask

    task automatic test_zero_and_overflow();
        issue_all_ops(32'd123, 32'd0);
        issue_all_ops(32'hFFFF_FFFB, 32'd0);
        issue_all_ops(MOST_NEG, ALL_ONES);
        drain();
    endtask

    // Second of the pair reuses the stored result, done one cycle later
    task automatic reuse_pair(input div_op_t first, input div_op_t second,
                              input div_word_t a, input div_word_t b);
        done_cycles.delete();
        issue(first, a, b);
        issue(second, a, b);
        drain();
        check_count(done_cycles.size(), 2, "done pulses of the pair");
        if (done_cycles.size() == 2)
            check_count(done_cycles[1] - done_cycles[0], 1, "cycles between pair dones");
    endtask

    task automatic test_burst();
        done_cycles.delete();
        ready_low_seen = 1'b0;
        for (int k = 0; k < 8; k++)
            issue(div_op_t'(k % 4), 32'd1000 + 32'(k * 37), 32'(k + 3));
        drain();
        check_flag(ready_low_seen, 1'b1, "ready low during burst");
        check_count(done_cycles.size(), 8, "burst results");
    endtask

    task automatic test_random();
        div_word_t op_bits;
        div_word_t a;
        div_word_t b;
        div_word_t shift;
        for (int n = 0; n < 40; n++) begin
            take_bits(2, op_bits);
            take_bits(`DIV_XLEN, a);
            take_bits(`DIV_XLEN, b);
            // Spread the divisor sizes
            take_bits(5, shift);
            issue(div_op_t'(op_bits[1:0]), a, b >> shift);
        end
        drain();
    endtask

    ////////////////////
    // Sequence

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        new_request     = 1'b0;
        op              = DIV_OP_DIV;
        rs1             = '0;
        rs2             = '0;
        req_id          = '0;
        can_issue       = 1'b1;
        ready_low_seen  = 1'b0;
        cycle           = 0;
        issued          = 0;
        results_checked = 0;
        value_errors    = 0;
        protocol_errors = 0;
        next_id         = '0;
        lfsr            = 32'd1;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        test_mixed_signs();
        test_zero_and_overflow();
        reuse_pair(DIV_OP_DIV, DIV_OP_REM, 32'hFFFF_FC18, 32'd7);
        reuse_pair(DIV_OP_REMU, DIV_OP_DIVU, 32'hDEAD_BEEF, 32'h0000_1234);
        test_burst();
        test_random();

        check_count(results_checked, issued, "results returned");
        assert_failures = div_subsystem_inst.div_unit_inst.div_assert_inst.fail_count;
        $display("Summary: %0d results, %0d value errors, %0d protocol errors, %0d assertion failures",
                 results_checked, value_errors, protocol_errors, assert_failures);
        if (value_errors + protocol_errors + assert_failures == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: div_subsystem.f
+incdir+source
source/div_pkg.sv
source/fifo_if.sv
source/div_fifo.sv
source/radix2_divider.sv
source/div_unit.sv
source/div_subsystem.sv
dv/div_assert.sv
dv/div_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f div_subsystem.f --top-module div_tb -o div_tb_sim

output="$(./obj_dir/div_tb_sim +verilator+error+limit+1000)"
echo "$output"

if grep -q 'All tests passed!' <<< "$output"; then
    exit 0
fi
exit 1
